// File: common/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int TAPS        = 3;
    localparam int MAX_ROW_LEN = 64;

    // axi4-lite control port
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    localparam logic [AXI_ADDR_W-1:0] REG_CTRL      = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS    = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_ROW_LEN   = 4'h8;
    localparam logic [AXI_ADDR_W-1:0] REG_ROW_COUNT = 4'hc;

    typedef logic signed [7:0]  sample_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic [TAPS*$bits(weight_t)-1:0] weight_vec_t;  // element 0 = oldest sample
    typedef logic signed [19:0] acc_t;

    typedef logic [$clog2(MAX_ROW_LEN+1)-1:0] row_len_t;
    typedef logic [5:0]                        row_cnt_t;

    typedef enum logic [2:0] {
        PASS_IDLE,
        INIT_WEIGHT,
        INIT_FIFO_PE,
        PREHEAT,
        NORMAL_LOOP,
        PASS_DONE
    } pass_state_t;

endpackage

`default_nettype wire

// File: design/axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_regs import conv_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire  [AXI_ADDR_W-1:0]   awaddr_i,
    input  wire                     awvalid_i,
    output logic                    awready_o,
    input  wire  [AXI_DATA_W-1:0]   wdata_i,
    input  wire  [AXI_DATA_W/8-1:0] wstrb_i,
    input  wire                     wvalid_i,
    output logic                    wready_o,
    output logic [1:0]              bresp_o,
    output logic                    bvalid_o,
    input  wire                     bready_i,
    input  wire  [AXI_ADDR_W-1:0]   araddr_i,
    input  wire                     arvalid_i,
    output logic                    arready_o,
    output logic [AXI_DATA_W-1:0]   rdata_o,
    output logic [1:0]              rresp_o,
    output logic                    rvalid_o,
    input  wire                     rready_i,

    input  wire                     pass_done_i,
    output logic                    pass_start_o,
    output row_len_t                row_len_o,
    output row_cnt_t                row_count_o
);

    logic                    aw_got, w_got;
    logic [AXI_ADDR_W-1:0]   awaddr_q;
    logic [AXI_DATA_W-1:0]   wdata_q;
    logic                    wstrb0_q;
    logic                    aw_fire, w_fire, wr_en, b_fire, ar_fire;
    logic [AXI_ADDR_W-1:0]   wr_addr;
    logic [AXI_DATA_W-1:0]   wr_data;
    logic                    wr_byte0;
    logic                    start_pend, busy, done;

    assign awready_o = !aw_got && !bvalid_o;
    assign wready_o  = !w_got && !bvalid_o;
    assign aw_fire   = awvalid_i && awready_o;
    assign w_fire    = wvalid_i && wready_o;
    assign b_fire    = bvalid_o && bready_i;
    assign arready_o = !rvalid_o;
    assign ar_fire   = arvalid_i && arready_o;
    assign bresp_o   = 2'b00;  // always OKAY
    assign rresp_o   = 2'b00;

    // address and data may come in either order
    assign wr_addr  = aw_got ? awaddr_q : awaddr_i;
    assign wr_data  = w_got ? wdata_q : wdata_i;
    assign wr_byte0 = w_got ? wstrb0_q : wstrb_i[0];
    assign wr_en    = (aw_got || aw_fire) && (w_got || w_fire);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_got       <= 1'b0;
            w_got        <= 1'b0;
            bvalid_o     <= 1'b0;
            rvalid_o     <= 1'b0;
            start_pend   <= 1'b0;
            pass_start_o <= 1'b0;
            busy         <= 1'b0;
            done         <= 1'b0;
            row_len_o    <= '0;
            row_count_o  <= '0;
        end else begin
            aw_got <= (aw_got || aw_fire) && !wr_en;
            w_got  <= (w_got || w_fire) && !wr_en;
            if (wr_en)
                bvalid_o <= 1'b1;
            else if (b_fire)
                bvalid_o <= 1'b0;
            if (ar_fire)
                rvalid_o <= 1'b1;
            else if (rready_i)
                rvalid_o <= 1'b0;

            if (wr_en && wr_byte0) begin
                case (wr_addr)
                    REG_CTRL:      start_pend  <= wr_data[0];
                    REG_ROW_LEN:   row_len_o   <= wr_data[$bits(row_len_t)-1:0];
                    REG_ROW_COUNT: row_count_o <= wr_data[$bits(row_cnt_t)-1:0];
                    default:       ;
                endcase
            end

            // start fires once the response has been taken
            pass_start_o <= b_fire && start_pend && !busy;
            if (b_fire)
                start_pend <= 1'b0;
            if (pass_start_o) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (pass_done_i) begin
                busy <= 1'b0;
                done <= 1'b1;  // sticky until the next start
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire)
            awaddr_q <= awaddr_i;
        if (w_fire) begin
            wdata_q  <= wdata_i;
            wstrb0_q <= wstrb_i[0];
        end
        if (ar_fire) begin
            case (araddr_i)
                REG_STATUS:    rdata_o <= {{(AXI_DATA_W-2){1'b0}}, done, busy};
                REG_ROW_LEN:   rdata_o <= AXI_DATA_W'(row_len_o);
                REG_ROW_COUNT: rdata_o <= AXI_DATA_W'(row_count_o);
                default:       rdata_o <= '0;  // ctrl reads as zero
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/pass_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pass_ctrl import conv_pkg::*; (
    input  wire  clk,
    input  wire  rst_n,

    input  wire  pass_start_i,
    output logic pass_done_o,

    // phase ends reported by the lower blocks
    input  wire  weight_load_done_i,
    input  wire  preheat_done_i,
    input  wire  normal_loop_done_i,
    input  wire  all_row_finish_i,

    output logic weight_load_state_o,
    output logic init_fifo_pe_state_o,
    output logic preheat_state_o,
    output logic normal_loop_state_o
);

    pass_state_t state_q, state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= PASS_IDLE;
        else
            state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            PASS_IDLE: begin
                if (pass_start_i)
                    state_d = INIT_WEIGHT;
            end
            INIT_WEIGHT: begin
                if (weight_load_done_i)
                    state_d = INIT_FIFO_PE;
            end
            INIT_FIFO_PE: begin
                state_d = PREHEAT;  // window clear takes one cycle
            end
            PREHEAT: begin
                if (preheat_done_i)
                    state_d = NORMAL_LOOP;
            end
            NORMAL_LOOP: begin
                if (normal_loop_done_i) begin
                    if (all_row_finish_i)
                        state_d = PASS_DONE;
                    else
                        state_d = INIT_FIFO_PE;  // next row
                end
            end
            PASS_DONE: begin
                state_d = PASS_IDLE;
            end
            default: state_d = PASS_IDLE;
        endcase
    end

    assign weight_load_state_o  = (state_q == INIT_WEIGHT);
    assign init_fifo_pe_state_o = (state_q == INIT_FIFO_PE);
    assign preheat_state_o      = (state_q == PREHEAT);
    assign normal_loop_state_o  = (state_q == NORMAL_LOOP);
    assign pass_done_o          = (state_q == PASS_DONE);

endmodule

`default_nettype wire

// File: design/weight_loader.sv
`timescale 1ns/1ps
`default_nettype none

module weight_loader import conv_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,

    input  wire         weight_load_state_i,
    input  wire         weight_valid_i,
    input  weight_t     weight_data_i,
    output logic        weight_ready_o,

    output weight_vec_t weights_o,
    output logic        weight_load_done_o
);

    localparam int WW = $bits(weight_t);

    logic [$clog2(TAPS)-1:0] tap_idx;
    logic                    weight_fire;
    weight_vec_t             weights_q;

    assign weight_ready_o     = weight_load_state_i;
    assign weight_fire        = weight_valid_i && weight_ready_o;
    assign weight_load_done_o = weight_fire && (tap_idx == TAPS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tap_idx <= '0;
        else if (!weight_load_state_i)
            tap_idx <= '0;  // rewind between passes
        else if (weight_fire)
            tap_idx <= tap_idx + 1'b1;
    end

    // held for the whole pass once loaded
    always_ff @(posedge clk) begin
        if (weight_fire)
            weights_q[tap_idx*WW +: WW] <= weight_data_i;
    end

    assign weights_o = weights_q;

endmodule

`default_nettype wire

// File: row_engine/row_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module row_ctrl import conv_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,

    input  row_len_t row_len_i,
    input  row_cnt_t row_count_i,

    input  wire      init_fifo_pe_state_i,
    input  wire      preheat_state_i,
    input  wire      normal_loop_state_i,

    input  wire      sample_fire_i,
    input  wire      out_fire_i,

    output logic     sample_take_o,
    output logic     preheat_done_o,
    output logic     normal_loop_done_o,
    output logic     all_row_finish_o
);

    row_len_t samp_cnt;   // samples taken in this phase
    row_len_t out_cnt;    // results accepted in this row
    row_cnt_t row_idx;
    row_len_t loop_len;   // samples needed by the normal loop
    logic     running;

    assign loop_len = row_len_i - row_len_t'(TAPS - 1);
    assign running  = init_fifo_pe_state_i || preheat_state_i || normal_loop_state_i;

    assign sample_take_o = (preheat_state_i && (samp_cnt < row_len_t'(TAPS - 1)))
                        || (normal_loop_state_i && (samp_cnt < loop_len));

    assign preheat_done_o = preheat_state_i && sample_fire_i
                         && (samp_cnt == row_len_t'(TAPS - 2));

    // last valid result of the row
    assign normal_loop_done_o = normal_loop_state_i && out_fire_i
                             && (out_cnt == row_len_i - row_len_t'(TAPS));

    assign all_row_finish_o = (row_idx == row_count_i - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            samp_cnt <= '0;
            out_cnt  <= '0;
        end else if (init_fifo_pe_state_i) begin
            samp_cnt <= '0;
            out_cnt  <= '0;
        end else begin
            if (preheat_done_o)
                samp_cnt <= '0;  // loop counts afresh
            else if (sample_fire_i)
                samp_cnt <= samp_cnt + 1'b1;
            if (out_fire_i)
                out_cnt <= out_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            row_idx <= '0;
        else if (!running)
            row_idx <= '0;  // back to row 0 outside a pass
        else if (normal_loop_done_o)
            row_idx <= row_idx + 1'b1;
    end

endmodule

`default_nettype wire

// File: row_engine/pe_row.sv
`timescale 1ns/1ps
`default_nettype none

module pe_row import conv_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,

    input  wire         init_fifo_pe_state_i,
    input  wire         normal_loop_state_i,
    input  wire         sample_take_i,
    input  weight_vec_t weights_i,

    input  wire         s_valid_i,
    input  sample_t     s_data_i,
    output logic        s_ready_o,

    output logic        r_valid_o,
    output acc_t        r_data_o,
    input  wire         r_ready_i,

    output logic        sample_fire_o,
    output logic        out_fire_o
);

    localparam int WW = $bits(weight_t);

    sample_t win_q    [TAPS];
    sample_t win_next [TAPS];
    acc_t    dot;
    logic    load_res;

    // stall input while a result waits
    assign s_ready_o     = sample_take_i && (!r_valid_o || r_ready_i);
    assign sample_fire_o = s_valid_i && s_ready_o;
    assign out_fire_o    = r_valid_o && r_ready_i;
    assign load_res      = sample_fire_o && normal_loop_state_i;

    always_comb begin
        for (int k = 0; k < TAPS - 1; k++)
            win_next[k] = win_q[k+1];
        win_next[TAPS-1] = s_data_i;  // newest at the top
    end

    always_comb begin
        weight_t w_k;
        acc_t    prod;
        dot = '0;
        for (int k = 0; k < TAPS; k++) begin
            w_k  = weight_t'(weights_i[k*WW +: WW]);
            prod = w_k * win_next[k];
            dot  = dot + prod;
        end
    end

    always_ff @(posedge clk) begin
        if (init_fifo_pe_state_i)
            win_q <= '{default: '0};
        else if (sample_fire_o)
            win_q <= win_next;
        if (load_res)
            r_data_o <= dot;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            r_valid_o <= 1'b0;
        else if (load_res)
            r_valid_o <= 1'b1;
        else if (out_fire_o)
            r_valid_o <= 1'b0;
    end

endmodule

`default_nettype wire

// File: design/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top import conv_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire  [AXI_ADDR_W-1:0]   s_axil_awaddr_i,
    input  wire                     s_axil_awvalid_i,
    output logic                    s_axil_awready_o,
    input  wire  [AXI_DATA_W-1:0]   s_axil_wdata_i,
    input  wire  [AXI_DATA_W/8-1:0] s_axil_wstrb_i,
    input  wire                     s_axil_wvalid_i,
    output logic                    s_axil_wready_o,
    output logic [1:0]              s_axil_bresp_o,
    output logic                    s_axil_bvalid_o,
    input  wire                     s_axil_bready_i,
    input  wire  [AXI_ADDR_W-1:0]   s_axil_araddr_i,
    input  wire                     s_axil_arvalid_i,
    output logic                    s_axil_arready_o,
    output logic [AXI_DATA_W-1:0]   s_axil_rdata_o,
    output logic [1:0]              s_axil_rresp_o,
    output logic                    s_axil_rvalid_o,
    input  wire                     s_axil_rready_i,

    input  wire                     weight_valid_i,
    input  weight_t                 weight_data_i,
    output logic                    weight_ready_o,

    input  wire                     s_valid_i,
    input  sample_t                 s_data_i,
    output logic                    s_ready_o,

    output logic                    r_valid_o,
    output acc_t                    r_data_o,
    input  wire                     r_ready_i
);

    logic        pass_start, pass_done;
    row_len_t    row_len;
    row_cnt_t    row_count;
    logic        weight_load_state, init_fifo_pe_state, preheat_state, normal_loop_state;
    logic        weight_load_done, preheat_done, normal_loop_done, all_row_finish;
    logic        sample_take, sample_fire, out_fire;
    weight_vec_t weights;

    axil_regs u_regs (
        .clk, .rst_n,
        .awaddr_i (s_axil_awaddr_i),  .awvalid_i (s_axil_awvalid_i),
        .awready_o(s_axil_awready_o), .wdata_i   (s_axil_wdata_i),
        .wstrb_i  (s_axil_wstrb_i),   .wvalid_i  (s_axil_wvalid_i),
        .wready_o (s_axil_wready_o),  .bresp_o   (s_axil_bresp_o),
        .bvalid_o (s_axil_bvalid_o),  .bready_i  (s_axil_bready_i),
        .araddr_i (s_axil_araddr_i),  .arvalid_i (s_axil_arvalid_i),
        .arready_o(s_axil_arready_o), .rdata_o   (s_axil_rdata_o),
        .rresp_o  (s_axil_rresp_o),   .rvalid_o  (s_axil_rvalid_o),
        .rready_i (s_axil_rready_i),
        .pass_done_i (pass_done),     .pass_start_o(pass_start),
        .row_len_o   (row_len),       .row_count_o (row_count)
    );

    pass_ctrl u_pass_ctrl (
        .clk, .rst_n,
        .pass_start_i        (pass_start),         .pass_done_o         (pass_done),
        .weight_load_done_i  (weight_load_done),   .preheat_done_i      (preheat_done),
        .normal_loop_done_i  (normal_loop_done),   .all_row_finish_i    (all_row_finish),
        .weight_load_state_o (weight_load_state),  .init_fifo_pe_state_o(init_fifo_pe_state),
        .preheat_state_o     (preheat_state),      .normal_loop_state_o (normal_loop_state)
    );

    weight_loader u_weights (
        .clk, .rst_n,
        .weight_load_state_i(weight_load_state),
        .weight_valid_i, .weight_data_i, .weight_ready_o,
        .weights_o          (weights),
        .weight_load_done_o (weight_load_done)
    );

    row_ctrl u_row_ctrl (
        .clk, .rst_n,
        .row_len_i           (row_len),            .row_count_i        (row_count),
        .init_fifo_pe_state_i(init_fifo_pe_state), .preheat_state_i    (preheat_state),
        .normal_loop_state_i (normal_loop_state),
        .sample_fire_i       (sample_fire),        .out_fire_i         (out_fire),
        .sample_take_o       (sample_take),        .preheat_done_o     (preheat_done),
        .normal_loop_done_o  (normal_loop_done),   .all_row_finish_o   (all_row_finish)
    );

    pe_row u_pe_row (
        .clk, .rst_n,
        .init_fifo_pe_state_i(init_fifo_pe_state),
        .normal_loop_state_i (normal_loop_state),
        .sample_take_i       (sample_take),
        .weights_i           (weights),
        .s_valid_i, .s_data_i, .s_ready_o,
        .r_valid_o, .r_data_o, .r_ready_i,
        .sample_fire_o       (sample_fire),
        .out_fire_o          (out_fire)
    );

endmodule

`default_nettype wire

// File: sim/conv_tb_tasks.svh
// register write with address and data offered together
task automatic write_reg(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data);
    bit aw_done;
    bit w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(negedge clk);
    s_axil_awaddr  = addr;
    s_axil_awvalid = 1'b1;
    s_axil_wdata   = data;
    s_axil_wstrb   = '1;
    s_axil_wvalid  = 1'b1;
    s_axil_bready  = 1'b1;
    while (!(aw_done && w_done)) begin
        @(posedge clk);
        if (s_axil_awvalid && s_axil_awready)
            aw_done = 1'b1;
        if (s_axil_wvalid && s_axil_wready)
            w_done = 1'b1;
        @(negedge clk);
        if (aw_done)
            s_axil_awvalid = 1'b0;
        if (w_done)
            s_axil_wvalid = 1'b0;
    end
    do @(posedge clk); while (!s_axil_bvalid);  // response taken here
    check_equal("BRESP", 0, s_axil_bresp);      // OKAY
    @(negedge clk);
    s_axil_bready = 1'b0;
endtask

task automatic read_reg(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data);
    @(negedge clk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    s_axil_rready  = 1'b1;
    do @(posedge clk); while (!s_axil_arready);
    @(negedge clk);
    s_axil_arvalid = 1'b0;
    do @(posedge clk); while (!s_axil_rvalid);
    data = s_axil_rdata;
    check_equal("RRESP", 0, s_axil_rresp);
    @(negedge clk);
    s_axil_rready = 1'b0;
endtask

task automatic send_weights();
    for (int k = 0; k < TAPS; k++) begin
        @(negedge clk);
        weight_valid = 1'b1;
        weight_data  = cur_w[k*$bits(weight_t) +: $bits(weight_t)];  // element 0 first
        do @(posedge clk); while (!weight_ready);
    end
    @(negedge clk);
    weight_valid = 1'b0;
endtask

task automatic send_samples(input bit gaps);
    for (int n = 0; n < stim.size(); n++) begin
        @(negedge clk);
        if (gaps) begin
            while (($random(seed) & 3) == 0) begin
                s_valid = 1'b0;  // idle cycle
                @(negedge clk);
            end
        end
        s_valid = 1'b1;
        s_data  = stim[n];
        do @(posedge clk); while (!s_ready);
    end
    @(negedge clk);
    s_valid = 1'b0;
endtask

// File: sim/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tb import conv_pkg::*; ();

    // sample count of all tests for the watchdog limit
    localparam int TOTAL_SAMPLES = 1*8 + 4*10 + 3*10 + 2*12;

    logic                    clk;
    logic                    rst_n;
    logic [AXI_ADDR_W-1:0]   s_axil_awaddr, s_axil_araddr;
    logic                    s_axil_awvalid, s_axil_awready;
    logic [AXI_DATA_W-1:0]   s_axil_wdata, s_axil_rdata;
    logic [AXI_DATA_W/8-1:0] s_axil_wstrb;
    logic                    s_axil_wvalid, s_axil_wready;
    logic [1:0]              s_axil_bresp, s_axil_rresp;
    logic                    s_axil_bvalid, s_axil_bready;
    logic                    s_axil_arvalid, s_axil_arready;
    logic                    s_axil_rvalid, s_axil_rready;
    logic                    weight_valid, weight_ready;
    weight_t                 weight_data;
    logic                    s_valid, s_ready;
    sample_t                 s_data;
    logic                    r_valid, r_ready;
    acc_t                    r_data;

    integer      seed;
    int          errors, err_mark, n_pass, n_fail, got_cnt;
    string       test_name;
    sample_t     stim [$];
    acc_t        exp_q [$];
    acc_t        exp_v;
    weight_vec_t cur_w;
    bit          bp_on;
    logic [31:0] rd;

    conv_top uut (
        .clk, .rst_n,
        .s_axil_awaddr_i (s_axil_awaddr),  .s_axil_awvalid_i(s_axil_awvalid),
        .s_axil_awready_o(s_axil_awready), .s_axil_wdata_i  (s_axil_wdata),
        .s_axil_wstrb_i  (s_axil_wstrb),   .s_axil_wvalid_i (s_axil_wvalid),
        .s_axil_wready_o (s_axil_wready),  .s_axil_bresp_o  (s_axil_bresp),
        .s_axil_bvalid_o (s_axil_bvalid),  .s_axil_bready_i (s_axil_bready),
        .s_axil_araddr_i (s_axil_araddr),  .s_axil_arvalid_i(s_axil_arvalid),
        .s_axil_arready_o(s_axil_arready), .s_axil_rdata_o  (s_axil_rdata),
        .s_axil_rresp_o  (s_axil_rresp),   .s_axil_rvalid_o (s_axil_rvalid),
        .s_axil_rready_i (s_axil_rready),
        .weight_valid_i(weight_valid), .weight_data_i(weight_data), .weight_ready_o(weight_ready),
        .s_valid_i     (s_valid),      .s_data_i     (s_data),      .s_ready_o     (s_ready),
        .r_valid_o     (r_valid),      .r_data_o     (r_data),      .r_ready_i     (r_ready)
    );

    `include "conv_tb_tasks.svh"

    // sum over taps of weight[k] * sample[i+k] within one row
    function automatic acc_t conv_ref(input int row, input int row_len, input weight_vec_t w,
                                      input int idx);
        int      acc;
        int      base;
        weight_t wk;
        acc  = 0;
        base = row * row_len + idx;
        for (int k = 0; k < TAPS; k++) begin
            wk  = w[k*$bits(weight_t) +: $bits(weight_t)];
            acc = acc + wk * stim[base + k];
        end
        return acc_t'(acc);
    endfunction

    task automatic check_equal(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("[ERROR] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic set_weights(input weight_t w0, input weight_t w1, input weight_t w2);
        cur_w = {w2, w1, w0};
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
        got_cnt   = 0;
    endtask

    task automatic finish_test();
        if (errors == err_mark) begin
            n_pass++;
            $display("test %s: ok, %0d results", test_name, got_cnt);
        end else begin
            n_fail++;
            $display("test %s: FAILED with %0d errors", test_name, errors - err_mark);
        end
    endtask

    // random row data and the queue of expected results
    task automatic start_pass(input int rows, input int len);
        stim.delete();
        for (int n = 0; n < rows * len; n++)
            stim.push_back(sample_t'($random(seed)));
        for (int r = 0; r < rows; r++)
            for (int i = 0; i <= len - TAPS; i++)
                exp_q.push_back(conv_ref(r, len, cur_w, i));
        write_reg(REG_ROW_LEN, len);
        write_reg(REG_ROW_COUNT, rows);
        write_reg(REG_CTRL, 32'h1);
    endtask

    // poll until done while busy holds
    task automatic wait_pass_done(input int n_results);
        logic [31:0] st;
        st = '0;
        while (!st[1]) begin
            read_reg(REG_STATUS, st);
            if (!st[1])
                assert (st[0]) else begin
                    $display("%s: busy went low before the pass finished", test_name);
                    errors++;
                end
        end
        check_equal("STATUS", 2, st);
        check_equal("result count", n_results, got_cnt);
        check_equal("results still queued", 0, exp_q.size());
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (bp_on)
            r_ready = ($random(seed) & 3) != 0;  // low about a quarter of the time
        else
            r_ready = 1'b1;
    end

    // compare every result transfer against the queue
    always @(posedge clk) begin
        if (r_valid && r_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("%s: result %0d arrived when none was expected", test_name, r_data);
                errors++;
            end
            if (exp_q.size() > 0) begin
                exp_v = exp_q.pop_front();
                assert (r_data == exp_v) else begin
                    $display("[ERROR] %s: result %0d expected %0d, actual %0d",
                             test_name, got_cnt, exp_v, r_data);
                    errors++;
                end
            end
            got_cnt++;
        end
    end

    initial begin
        repeat (TOTAL_SAMPLES * 40 + 2000) @(posedge clk);
        $display("timeout: the run did not finish in time, %0d results in the current test",
                 got_cnt);
        $display("tests failed");
        $finish;
    end

    initial begin
        seed           = 93;
        rst_n          = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        weight_valid   = 1'b0;
        weight_data    = '0;
        s_valid        = 1'b0;
        s_data         = '0;
        r_ready        = 1'b0;
        bp_on          = 1'b0;
        errors         = 0;
        n_pass         = 0;
        n_fail         = 0;
        cur_w          = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_regs");
        @(negedge clk);
        check_equal("weight_ready_o", 0, weight_ready);
        check_equal("s_ready_o", 0, s_ready);
        check_equal("r_valid_o", 0, r_valid);
        write_reg(REG_ROW_LEN, 37);
        write_reg(REG_ROW_COUNT, 21);
        read_reg(REG_ROW_LEN, rd);
        check_equal("ROW_LEN", 37, rd);
        read_reg(REG_ROW_COUNT, rd);
        check_equal("ROW_COUNT", 21, rd);
        read_reg(REG_STATUS, rd);
        check_equal("STATUS", 0, rd);
        finish_test();

        start_test("single_row");
        set_weights(3, -2, 5);
        start_pass(1, 8);
        send_weights();
        send_samples(1'b0);
        wait_pass_done(6);
        finish_test();

        start_test("rows_backpressure");
        bp_on = 1'b1;
        start_pass(4, 10);
        send_weights();
        send_samples(1'b1);
        wait_pass_done(32);
        finish_test();

        start_test("start_while_busy");
        start_pass(3, 10);
        fork
            begin
                send_weights();
                send_samples(1'b1);
            end
            begin
                wait (got_cnt >= 3);
                write_reg(REG_CTRL, 32'h1);  // must be ignored
                read_reg(REG_STATUS, rd);
                check_equal("STATUS during pass", 1, rd);
            end
        join
        wait_pass_done(24);
        finish_test();

        start_test("weight_reload");
        bp_on = 1'b0;
        set_weights(-7, 4, 1);
        start_pass(2, 12);
        send_weights();
        send_samples(1'b1);
        wait_pass_done(20);
        finish_test();

        $display("summary: %0d passed, %0d failed", n_pass, n_fail);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+sim
common/conv_pkg.sv
design/axil_regs.sv
design/pass_ctrl.sv
design/weight_loader.sv
row_engine/row_ctrl.sv
row_engine/pe_row.sv
design/conv_top.sv
sim/conv_tb.sv

// File: Bender.yml
package:
  name: conv_engine

sources:
  - common/conv_pkg.sv
  - design/axil_regs.sv
  - design/pass_ctrl.sv
  - design/weight_loader.sv
  - row_engine/row_ctrl.sv
  - row_engine/pe_row.sv
  - design/conv_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/conv_tb.sv
